// ==== hdl/xt_isa_pkg.sv ====
`default_nettype none

package xt_isa_pkg;

    localparam int data_w = 24;

    // Fields stay plain vectors so unlisted encodings survive decode
    typedef struct packed {
        logic [3:0]        opclass;
        logic [3:0]        subop;
        logic [data_w-9:0] operand;
    } instr_t;

    typedef enum logic [3:0] {
        oc_0    = 4'h0,
        oc_1    = 4'h1,
        oc_2    = 4'h2,
        oc_3    = 4'h3,
        oc_4    = 4'h4,
        oc_5    = 4'h5,
        oc_ctrl = 4'h6,
        oc_7    = 4'h7,
        oc_priv = 4'h9,
        oc_f    = 4'hf
    } opclass_e;

    // Control subops live in class 6, SETSSP in class 9
    typedef enum logic [3:0] {
        sub_btp    = 4'h0,
        sub_jccui  = 4'h1,
        sub_bccsr  = 4'h2,
        sub_bccso  = 4'h3,
        sub_balso  = 4'h4,
        sub_jsrui  = 4'h5,
        sub_bsrsr  = 4'h6,
        sub_bsrso  = 4'h7,
        sub_ret    = 4'h8,
        sub_setssp = 4'hc
    } subop_e;

    // Opcode byte is {opclass, subop} of the matching instruction
    typedef enum logic [7:0] {
        opc_nop      = 8'h00,
        opc_jccui    = 8'h61,
        opc_bccsr    = 8'h62,
        opc_bccso    = 8'h63,
        opc_balso    = 8'h64,
        opc_srmovur  = 8'h70,
        opc_srmovaur = 8'h71,
        opc_sraddsi  = 8'h72,
        opc_srsubsi  = 8'h73,
        opc_srldso   = 8'h74,
        opc_srstso   = 8'h75,
        opc_srjccso  = 8'h76
    } opc_e;

    typedef enum logic [1:0] {
        sr_lr  = 2'd0,
        sr_ssp = 2'd1,
        sr_pc  = 2'd2
    } sr_idx_e;

    function automatic instr_t pack_nop();
        return instr_t'({opc_nop, 16'h0000});
    endfunction

    function automatic instr_t pack_sr_imm14(opc_e opc, sr_idx_e tgt_sr, logic [13:0] imm14);
        return instr_t'({opc, tgt_sr, imm14});
    endfunction

    function automatic instr_t pack_sr_sr_imm12(opc_e opc, sr_idx_e tgt_sr, sr_idx_e src_sr,
                                                logic [11:0] imm12);
        return instr_t'({opc, tgt_sr, src_sr, imm12});
    endfunction

    function automatic instr_t pack_sr_sr(opc_e opc, sr_idx_e tgt_sr, sr_idx_e src_sr);
        return instr_t'({opc, tgt_sr, src_sr, 12'h000});
    endfunction

    function automatic instr_t pack_sr_cc_imm10(opc_e opc, sr_idx_e tgt_sr, logic [3:0] cc,
                                                logic [9:0] imm10);
        return instr_t'({opc, tgt_sr, cc, imm10});
    endfunction

    function automatic instr_t pack_jccui(logic [3:0] cc, logic [11:0] imm12);
        return instr_t'({opc_jccui, cc, imm12});
    endfunction

    // Target data register sits above the condition code
    function automatic instr_t pack_bccsr(logic [3:0] tgt_dr, logic [3:0] cc);
        return instr_t'({opc_bccsr, tgt_dr, cc, 8'h00});
    endfunction

    function automatic instr_t pack_balso(logic [15:0] imm16);
        return instr_t'({opc_balso, imm16});
    endfunction

endpackage

`default_nettype wire

// ==== hdl/xt_pipe_pkg.sv ====
`default_nettype none

package xt_pipe_pkg;
    import xt_isa_pkg::*;

    localparam int fetch_pc_w = 24;

    typedef enum logic [2:0] {
        k_pass   = 3'd0,
        k_nop    = 3'd1,
        k_zero   = 3'd2,
        k_setssp = 3'd3,
        k_jsr    = 3'd4,
        k_bsr_sr = 3'd5,
        k_bsr_so = 3'd6,
        k_ret    = 3'd7
    } macro_kind_e;

    typedef logic [1:0] seq_idx_t;

    // Micro-ops emitted for one macro
    function automatic logic [2:0] seq_len(macro_kind_e kind);
        case (kind)
            k_jsr, k_bsr_sr, k_bsr_so: return 3'd4;
            k_ret:                     return 3'd3;
            default:                   return 3'd1;
        endcase
    endfunction

    typedef struct packed {
        logic [fetch_pc_w-1:0] pc;
        instr_t                instr;
    } fetch_s;

    typedef struct packed {
        macro_kind_e kind;
        seq_idx_t    idx;
        instr_t      instr;
    } uop_req_s;

endpackage

`default_nettype wire

// ==== hdl/xt_classify.sv ====
`timescale 1ns/10ps
`default_nettype none

module xt_classify
    import xt_isa_pkg::*, xt_pipe_pkg::*;
(
    input  instr_t      instr,
    output macro_kind_e kind
);

    always_comb begin
        case (instr.opclass)
            oc_0, oc_1, oc_2, oc_3, oc_4, oc_5, oc_7, oc_f: begin
                kind = k_pass;
            end
            oc_ctrl: begin
                case (instr.subop)
                    sub_btp: begin
                        kind = k_nop;
                    end
                    // Plain branches go through untouched
                    sub_jccui, sub_bccsr, sub_bccso, sub_balso: begin
                        kind = k_pass;
                    end
                    sub_jsrui: begin
                        kind = k_jsr;
                    end
                    sub_bsrsr: begin
                        kind = k_bsr_sr;
                    end
                    sub_bsrso: begin
                        kind = k_bsr_so;
                    end
                    sub_ret: begin
                        kind = k_ret;
                    end
                    default: begin
                        kind = k_zero;
                    end
                endcase
            end
            oc_priv: begin
                // Other privileged ops pass unchanged
                if (instr.subop == sub_setssp) begin
                    kind = k_setssp;
                end else begin
                    kind = k_pass;
                end
            end
            default: begin
                kind = k_zero;
            end
        endcase
    end

    // A known instruction always lands on a known kind
    kind_known: assert final ($isunknown(instr) || !$isunknown(kind))
        else $error("xt_classify: kind unknown for instr %h", instr);

endmodule

`default_nettype wire

// ==== hdl/xt_uop_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module xt_uop_gen
    import xt_isa_pkg::*, xt_pipe_pkg::*;
(
    input  uop_req_s req,
    output instr_t   uop
);

    // Last micro-op of a call sequence, picked by kind
    instr_t call_tail;

    always_comb begin
        case (req.kind)
            k_jsr: begin
                call_tail = pack_jccui(4'h0, req.instr.operand[11:0]);
            end
            k_bsr_sr: begin
                call_tail = pack_bccsr(req.instr.operand[15:12], 4'h0);
            end
            default: begin
                call_tail = pack_balso(req.instr.operand);
            end
        endcase
    end

    always_comb begin
        case (req.kind)
            k_pass: begin
                uop = req.instr;
            end
            k_nop: begin
                uop = pack_nop();
            end
            k_setssp: begin
                uop = pack_sr_sr(opc_srmovaur, sr_ssp, sr_idx_e'(req.instr.operand[15:14]));
            end
            k_jsr, k_bsr_sr, k_bsr_so: begin
                // Push LR, save return PC, then branch
                case (req.idx)
                    2'd0: uop = pack_sr_imm14(opc_srsubsi, sr_ssp, 14'd2);
                    2'd1: uop = pack_sr_sr_imm12(opc_srstso, sr_ssp, sr_lr, 12'd0);
                    2'd2: uop = pack_sr_sr(opc_srmovur, sr_lr, sr_pc);
                    default: uop = call_tail;
                endcase
            end
            k_ret: begin
                // Pop LR and jump through it
                case (req.idx)
                    2'd0: uop = pack_sr_imm14(opc_sraddsi, sr_ssp, 14'd2);
                    2'd1: uop = pack_sr_sr_imm12(opc_srldso, sr_lr, sr_ssp, 12'hffe);
                    default: uop = pack_sr_cc_imm10(opc_srjccso, sr_lr, 4'h0, 10'd1);
                endcase
            end
            default: begin
                uop = '0;
            end
        endcase
    end

    // Sequencer never asks past the end of a sequence
    idx_in_range: assert final ($isunknown(req) || ({1'b0, req.idx} < seq_len(req.kind)))
        else $error("xt_uop_gen: index %0d out of range for kind %s",
                    req.idx, req.kind.name());

endmodule

`default_nettype wire

// ==== hdl/xt_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module xt_sequencer
    import xt_isa_pkg::*, xt_pipe_pkg::*;
#(
    parameter int addr_w = 24
) (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              stall,
    input  logic              flush,
    input  fetch_s            in_fetch,
    input  macro_kind_e       in_kind,
    output uop_req_s          req,
    input  instr_t            uop,
    output logic [addr_w-1:0] out_pc,
    output instr_t            out_uop,
    output logic              busy,
    output logic              seq_start
);

    if (addr_w != fetch_pc_w) begin : g_pc_w_check
        $error("xt_sequencer: addr_w must equal the fetch PC width");
    end

    seq_idx_t          idx;
    macro_kind_e       hold_kind;
    instr_t            hold_instr;
    logic [addr_w-1:0] hold_pc;
    logic [addr_w-1:0] sel_pc;
    logic              advance;
    logic [2:0]        next_idx;

    // Held macro drives generation while a sequence is in flight
    always_comb begin
        if (busy) begin
            req    = '{kind: hold_kind, idx: idx, instr: hold_instr};
            sel_pc = hold_pc;
        end else begin
            req    = '{kind: in_kind, idx: '0, instr: in_fetch.instr};
            sel_pc = in_fetch.pc;
        end
    end

    assign seq_start = !busy && (seq_len(in_kind) > 3'd1);
    assign advance   = !flush && !stall;
    assign next_idx  = 3'(idx) + 3'd1;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            busy      <= 1'b0;
            idx       <= '0;
            hold_kind <= k_pass;
            out_uop   <= '0;
            out_pc    <= '0;
        end else if (flush) begin
            busy    <= 1'b0;
            idx     <= '0;
            out_uop <= '0;
            out_pc  <= '0;
        end else if (!stall) begin
            out_uop <= uop;
            out_pc  <= sel_pc;
            if (busy) begin
                if (next_idx < seq_len(hold_kind)) begin
                    idx <= next_idx[1:0];
                end else begin
                    busy <= 1'b0;
                    idx  <= '0;
                end
            end else if (seq_start) begin
                // Micro-op 0 goes out now, so resume at 1
                busy      <= 1'b1;
                idx       <= 2'd1;
                hold_kind <= in_kind;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        if (advance && seq_start) begin
            hold_instr <= in_fetch.instr;
            hold_pc    <= in_fetch.pc;
        end
    end

    busy_idx_in_range: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        busy |-> ({1'b0, idx} < seq_len(hold_kind))
    ) else $error("xt_sequencer: index %0d past end of held sequence", idx);

    flush_clears_busy: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        flush |=> !busy
    ) else $error("xt_sequencer: busy still set after flush");

endmodule

`default_nettype wire

// ==== hdl/xt_translate_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module xt_translate_top
    import xt_isa_pkg::*, xt_pipe_pkg::*;
#(
    parameter int addr_w = 24
) (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              stall,
    input  logic              flush,
    input  fetch_s            in_fetch,
    output logic [addr_w-1:0] out_pc,
    output instr_t            out_uop,
    output logic              busy,
    output logic              seq_start
);

    macro_kind_e in_kind;
    uop_req_s    req;
    instr_t      uop;

    xt_classify u_classify (
        .instr (in_fetch.instr),
        .kind  (in_kind)
    );

    xt_sequencer #(
        .addr_w (addr_w)
    ) u_sequencer (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .stall     (stall),
        .flush     (flush),
        .in_fetch  (in_fetch),
        .in_kind   (in_kind),
        .req       (req),
        .uop       (uop),
        .out_pc    (out_pc),
        .out_uop   (out_uop),
        .busy      (busy),
        .seq_start (seq_start)
    );

    xt_uop_gen u_uop_gen (
        .req (req),
        .uop (uop)
    );

endmodule

`default_nettype wire

// ==== tb/tb_xt_translate.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_xt_translate
    import xt_isa_pkg::*, xt_pipe_pkg::*;
;

    localparam int addr_w       = 24;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    localparam int drive_dly    = 1;
    localparam int slack_cycles = 10;
    localparam     stim_path    = "tb/xt_translate_stim.txt";

    // One stim line, inputs first and expected outputs after the next edge
    typedef struct packed {
        logic              stall;
        logic              flush;
        logic [addr_w-1:0] pc;
        instr_t            instr;
        logic [addr_w-1:0] exp_pc;
        instr_t            exp_uop;
        logic              exp_busy;
    } stim_vec_s;

    logic              iw_clk;
    logic              iw_rst;
    logic              stall;
    logic              flush;
    fetch_s            in_fetch;
    logic [addr_w-1:0] out_pc;
    instr_t            out_uop;
    logic              busy;
    logic              seq_start;

    stim_vec_s         vecs[$];
    logic              stim_loaded = 1'b0;

    xt_translate_top #(
        .addr_w (addr_w)
    ) dut (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .stall     (stall),
        .flush     (flush),
        .in_fetch  (in_fetch),
        .out_pc    (out_pc),
        .out_uop   (out_uop),
        .busy      (busy),
        .seq_start (seq_start)
    );

    initial begin
        iw_clk = 1'b0;
        forever #(clk_period / 2) iw_clk = ~iw_clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string sig_name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                               $time, sig_name, got, exp));
        end
    endtask

    // Calls and returns in the control class expand into several micro-ops
    function automatic logic expands_to_sequence(input instr_t instr);
        return instr.opclass == oc_ctrl &&
               (instr.subop == sub_jsrui || instr.subop == sub_bsrsr ||
                instr.subop == sub_bsrso || instr.subop == sub_ret);
    endfunction

    task automatic check_outputs(input int num, input stim_vec_s v);
        logic exp_seq_start;
        // A call or return waiting at an idle stage announces its sequence
        exp_seq_start = !v.exp_busy && expands_to_sequence(v.instr);
        check_value($sformatf("out_pc (vector %0d)", num), out_pc, v.exp_pc);
        check_value($sformatf("out_uop (vector %0d)", num), out_uop, v.exp_uop);
        check_value($sformatf("busy (vector %0d)", num), busy, v.exp_busy);
        check_value($sformatf("seq_start (vector %0d)", num), seq_start, exp_seq_start);
    endtask

    task automatic load_stim();
        int          fd;
        int          cnt;
        string       text;
        logic [23:0] col [7];
        stim_vec_s   v;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            stop_run($sformatf("Cannot open the stim file %s", stim_path));
        end
        while ($fgets(text, fd) != 0) begin
            // Lines starting with # are notes
            if (text.len() > 0 && text[0] != "#") begin
                cnt = $sscanf(text, "%h %h %h %h %h %h %h",
                              col[0], col[1], col[2], col[3], col[4], col[5], col[6]);
                if (cnt == 7) begin
                    v.stall    = col[0][0];
                    v.flush    = col[1][0];
                    v.pc       = col[2];
                    v.instr    = col[3];
                    v.exp_pc   = col[4];
                    v.exp_uop  = col[5];
                    v.exp_busy = col[6][0];
                    vecs.push_back(v);
                end else if (cnt > 0) begin
                    stop_run($sformatf("A stim line has %0d fields instead of 7: %s",
                                       cnt, text));
                end
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            stop_run("The stim file holds no vectors");
        end
        stim_loaded = 1'b1;
    endtask

    initial begin
        iw_rst   = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        in_fetch = '0;
        load_stim();
        repeat (reset_cycles) @(posedge iw_clk);
        #(drive_dly);
        iw_rst = 1'b0;
        check_value("out_uop after reset", out_uop, '0);
        check_value("out_pc after reset", out_pc, '0);
        check_value("busy after reset", busy, '0);
        check_value("seq_start after reset", seq_start, '0);
        // Drive each vector just after an edge, check just after the next one
        foreach (vecs[i]) begin
            stall          = vecs[i].stall;
            flush          = vecs[i].flush;
            in_fetch.pc    = vecs[i].pc;
            in_fetch.instr = vecs[i].instr;
            @(posedge iw_clk);
            #(drive_dly);
            check_outputs(i + 1, vecs[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

    // Reset, one cycle per vector, then some slack
    initial begin
        wait (stim_loaded);
        #((reset_cycles + vecs.size() + slack_cycles) * clk_period);
        stop_run("Timeout: the run did not reach its end in time");
    end

endmodule

`default_nettype wire

// ==== tb/xt_translate_stim.txt ====
# stall flush pc instr | expected after the next edge: out_pc out_uop busy
# all fields hex, one line per clock cycle
# plain classes pass unchanged
0 0 000100 012345 000100 012345 0
0 0 000104 1a5a5a 000104 1a5a5a 0
0 0 000108 2fffff 000108 2fffff 0
0 0 00010c 300001 00010c 300001 0
0 0 000110 4c0de0 000110 4c0de0 0
0 0 000114 5b1234 000114 5b1234 0
0 0 000118 7e4321 000118 7e4321 0
0 0 00011c f00abc 00011c f00abc 0
# control branches pass unchanged
0 0 000120 610123 000120 610123 0
0 0 000124 629800 000124 629800 0
0 0 000128 63ff00 000128 63ff00 0
0 0 00012c 64beef 00012c 64beef 0
# BTP, SETSSP, other privileged, unknown class and control subop
0 0 000130 60cafe 000130 000000 0
0 0 000134 9c8000 000134 716000 0
0 0 000138 9c3fff 000138 714000 0
0 0 00013c 931234 00013c 931234 0
0 0 000140 812345 000140 000000 0
0 0 000148 6a1111 000148 000000 0
# JSRui, BSRsr, BSRso, RET
0 0 000200 65abcd 000200 734002 1
0 0 000200 65abcd 000200 754000 1
0 0 000200 65abcd 000200 702000 1
0 0 000200 65abcd 000200 610bcd 0
0 0 000210 667123 000210 734002 1
0 0 000210 667123 000210 754000 1
0 0 000210 667123 000210 702000 1
0 0 000210 667123 000210 627000 0
0 0 000220 671234 000220 734002 1
0 0 000220 671234 000220 754000 1
0 0 000220 671234 000220 702000 1
0 0 000220 671234 000220 641234 0
0 0 000230 680000 000230 724002 1
0 0 000230 680000 000230 741ffe 1
0 0 000230 680000 000230 760001 0
0 0 000234 1a5a5a 000234 1a5a5a 0
# stall inside a JSRui sequence and while idle
0 0 000300 65000f 000300 734002 1
1 0 000300 65000f 000300 734002 1
1 0 000300 65000f 000300 734002 1
0 0 000300 65000f 000300 754000 1
0 0 000300 65000f 000300 702000 1
1 0 000300 65000f 000300 702000 1
0 0 000300 65000f 000300 61000f 0
1 0 000304 2abcde 000300 61000f 0
0 0 000304 2abcde 000304 2abcde 0
# flush inside BSRso, then flush with stall inside RET
0 0 000400 67f00d 000400 734002 1
0 0 000400 67f00d 000400 754000 1
0 1 000400 67f00d 000000 000000 0
0 0 000404 4abcde 000404 4abcde 0
0 0 000408 680000 000408 724002 1
1 1 000408 680000 000000 000000 0
0 0 00040c 680000 00040c 724002 1
0 0 00040c 680000 00040c 741ffe 1
0 0 00040c 680000 00040c 760001 0
0 0 000410 000000 000410 000000 0

// ==== xt_translate.f ====
hdl/xt_isa_pkg.sv
hdl/xt_pipe_pkg.sv
hdl/xt_classify.sv
hdl/xt_uop_gen.sv
hdl/xt_sequencer.sv
hdl/xt_translate_top.sv
tb/tb_xt_translate.sv

// ==== Bender.yml ====
package:
  name: xt_translate

sources:
  - files:
      - hdl/xt_isa_pkg.sv
      - hdl/xt_pipe_pkg.sv
      - hdl/xt_classify.sv
      - hdl/xt_uop_gen.sv
      - hdl/xt_sequencer.sv
      - hdl/xt_translate_top.sv
  - target: test
    files:
      - tb/tb_xt_translate.sv
